// File: mem_bus_pkg.sv
package mem_bus_pkg;

    // byte address as seen on the burst bus
    typedef logic [31:0] addr_t;

    // one beat of a read burst
    typedef logic [63:0] beat_t;

    // one full line, four beats wide
    typedef logic [255:0] line_t;

    // beats in one line burst
    localparam int BEATS_PER_LINE = 4;

    // byte offset bits inside a 32 byte line
    localparam int LINE_OFFSET_BITS = 5;

    // counts beats 0..3 within a burst
    typedef logic [1:0] beat_cnt_t;

endpackage : mem_bus_pkg

// File: fetch_pkg.sv
package fetch_pkg;

    // one RV32I instruction word
    typedef logic [31:0] word_t;

    // program counter, byte addressed
    typedef logic [31:0] pc_t;

    // word index inside a line (8 words of 4 bytes)
    localparam int WORD_SEL_BITS = 3;

    // boot address of the core
    localparam pc_t DEFAULT_RESET_PC = 32'h1eceb000;

    // entries in the instruction queue unless the top overrides it
    localparam int DEFAULT_QUEUE_DEPTH = 32;

endpackage : fetch_pkg

// File: burst_assembler.sv
`timescale 1ns/10ps

module burst_assembler (
    input  logic               clk,
    input  logic               rst,

    input  mem_bus_pkg::addr_t bmem_raddr_i,
    input  mem_bus_pkg::beat_t bmem_rdata_i,
    input  logic               bmem_rvalid_i,

    output mem_bus_pkg::line_t line_data_o,
    output mem_bus_pkg::addr_t line_addr_o,
    output logic               line_done_o
);

    import mem_bus_pkg::*;

    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS_PER_LINE - 1);

    beat_cnt_t beat_cnt_q;
    line_t     line_q;     // beats land here in address order
    addr_t     addr_q;
    logic      done_q;

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0; // single cycle strobe
            if (bmem_rvalid_i) begin
                if (beat_cnt_q == LAST_BEAT) begin
                    beat_cnt_q <= '0;
                    done_q     <= 1'b1;
                end else begin
                    beat_cnt_q <= beat_cnt_q + 1'b1;
                end
            end
        end
    end

    // payload side
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q[beat_cnt_q * $bits(beat_t) +: $bits(beat_t)] <= bmem_rdata_i;
            if (beat_cnt_q == '0) begin
                addr_q <= bmem_raddr_i; // every beat carries it, first one is enough
            end
        end
    end

    assign line_data_o = line_q;
    assign line_addr_o = addr_q;
    assign line_done_o = done_q;

endmodule : burst_assembler

// File: line_buffer.sv
`timescale 1ns/10ps

module line_buffer (
    input  logic               clk,
    input  logic               rst,

    input  fetch_pkg::pc_t     pc_i,

    input  mem_bus_pkg::line_t line_data_i,
    input  mem_bus_pkg::addr_t line_addr_i,
    input  logic               line_done_i,

    input  logic               bmem_ready_i,
    output mem_bus_pkg::addr_t bmem_addr_o,
    output logic               bmem_read_o,

    output logic               hit_o,
    output fetch_pkg::word_t   hit_word_o
);

    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam int TAG_BITS = $bits(addr_t) - LINE_OFFSET_BITS;

    typedef enum logic {
        LB_IDLE,
        LB_WAIT    // one refill in flight
    } lb_state_e;

    lb_state_e                  state_q;
    logic                       valid_q;
    logic                       armed_q;   // keeps the bus quiet through reset
    logic [TAG_BITS-1:0]        tag_q;
    line_t                      line_q;

    logic [TAG_BITS-1:0]        pc_tag;
    logic [WORD_SEL_BITS-1:0]   word_sel;
    logic                       miss_req;

    assign pc_tag   = pc_i[$bits(pc_t)-1:LINE_OFFSET_BITS];
    assign word_sel = pc_i[LINE_OFFSET_BITS-1 -: WORD_SEL_BITS];

    // lookup is purely combinational on the current pc
    assign hit_o      = valid_q && (tag_q == pc_tag);
    assign hit_word_o = line_q[word_sel * $bits(word_t) +: $bits(word_t)];

    // request the line holding pc, only when the bus can take it
    assign miss_req    = armed_q && (state_q == LB_IDLE) && !hit_o && bmem_ready_i;
    assign bmem_read_o = miss_req;
    assign bmem_addr_o = addr_t'({pc_tag, {LINE_OFFSET_BITS{1'b0}}});

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LB_IDLE;
            valid_q <= 1'b0;
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            unique case (state_q)
                LB_IDLE: begin
                    if (miss_req) begin
                        state_q <= LB_WAIT;
                    end
                end
                LB_WAIT: begin
                    if (line_done_i) begin
                        state_q <= LB_IDLE;
                    end
                end
                default: state_q <= LB_IDLE;
            endcase
            if (line_done_i) begin
                valid_q <= 1'b1; // usable from the next cycle on
            end
        end
    end

    // the refilled line and its tag
    always_ff @(posedge clk) begin
        if (line_done_i) begin
            line_q <= line_data_i;
            tag_q  <= line_addr_i[$bits(addr_t)-1:LINE_OFFSET_BITS];
        end
    end

endmodule : line_buffer

// File: pc_gen.sv
`timescale 1ns/10ps

module pc_gen #(
    parameter fetch_pkg::pc_t RESET_PC = fetch_pkg::DEFAULT_RESET_PC
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             redirect_i,
    input  fetch_pkg::pc_t   redirect_pc_i,

    input  logic             hit_i,
    input  fetch_pkg::word_t hit_word_i,
    input  logic             full_i,

    output fetch_pkg::pc_t   pc_o,
    output logic             enq_o,
    output fetch_pkg::word_t enq_inst_o,
    output logic             flush_o
);

    import fetch_pkg::*;

    pc_t  pc_q;
    pc_t  pc_d;
    logic advance;

    // one instruction per cycle as long as the line hits and there is room
    assign advance = hit_i && !full_i && !redirect_i;

    always_comb begin
        pc_d = pc_q; // hold on miss or full queue
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (advance) begin
            pc_d = pc_q + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o       = pc_q;
    assign enq_o      = advance;
    assign enq_inst_o = hit_word_i;
    assign flush_o    = redirect_i;  // queue drops at the same edge pc jumps

endmodule : pc_gen

// File: inst_queue.sv
`timescale 1ns/10ps

module inst_queue #(
    parameter int QUEUE_DEPTH = fetch_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             enq_i,
    input  fetch_pkg::word_t enq_inst_i,
    input  fetch_pkg::pc_t   enq_pc_i,
    input  logic             flush_i,
    input  logic             dequeue_i,

    output logic             full_o,
    output logic             valid_o,
    output fetch_pkg::word_t inst_o,
    output fetch_pkg::pc_t   pc_o
);

    import fetch_pkg::*;

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    localparam logic [PTR_BITS-1:0] LAST_IDX = PTR_BITS'(QUEUE_DEPTH - 1);

    word_t inst_mem [QUEUE_DEPTH];
    pc_t   pc_mem   [QUEUE_DEPTH];

    logic [PTR_BITS-1:0] head_q;   // oldest entry
    logic [PTR_BITS-1:0] tail_q;   // next free slot
    logic [CNT_BITS-1:0] count_q;

    logic push;
    logic pop;

    assign full_o  = (count_q == CNT_BITS'(QUEUE_DEPTH));
    assign valid_o = (count_q != '0);

    assign push = enq_i && !full_o;
    assign pop  = dequeue_i && valid_o; // pop on empty is ignored

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= (tail_q == LAST_IDX) ? '0 : tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= (head_q == LAST_IDX) ? '0 : head_q + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[tail_q] <= enq_inst_i;
            pc_mem[tail_q]   <= enq_pc_i;
        end
    end

    assign inst_o = inst_mem[head_q];
    assign pc_o   = pc_mem[head_q];

endmodule : inst_queue

// File: fetch_top.sv
`timescale 1ns/10ps

module fetch_top #(
    parameter fetch_pkg::pc_t RESET_PC    = fetch_pkg::DEFAULT_RESET_PC,
    parameter int             QUEUE_DEPTH = fetch_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic               clk,
    input  logic               rst,

    output mem_bus_pkg::addr_t bmem_addr_o,
    output logic               bmem_read_o,
    input  logic               bmem_ready_i,

    input  mem_bus_pkg::addr_t bmem_raddr_i,
    input  mem_bus_pkg::beat_t bmem_rdata_i,
    input  logic               bmem_rvalid_i,

    input  logic               redirect_i,
    input  fetch_pkg::pc_t     redirect_pc_i,

    input  logic               dequeue_i,
    output logic               inst_valid_o,
    output fetch_pkg::word_t   inst_o,
    output fetch_pkg::pc_t     inst_pc_o
);

    import mem_bus_pkg::*;
    import fetch_pkg::*;

    line_t line_data;
    addr_t line_addr;
    logic  line_done;

    pc_t   pc;
    logic  hit;
    word_t hit_word;

    logic  enq;
    word_t enq_inst;
    logic  flush;
    logic  full;

    burst_assembler burst_assembler_i (
        .clk           (clk),
        .rst           (rst),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_data_o   (line_data),
        .line_addr_o   (line_addr),
        .line_done_o   (line_done)
    );

    line_buffer line_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc),
        .line_data_i  (line_data),
        .line_addr_i  (line_addr),
        .line_done_i  (line_done),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .hit_o        (hit),
        .hit_word_o   (hit_word)
    );

    pc_gen #(.RESET_PC(RESET_PC)) pc_gen_i (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .hit_i         (hit),
        .hit_word_i    (hit_word),
        .full_i        (full),
        .pc_o          (pc),
        .enq_o         (enq),
        .enq_inst_o    (enq_inst),
        .flush_o       (flush)
    );

    // pc travels with its instruction
    inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) inst_queue_i (
        .clk        (clk),
        .rst        (rst),
        .enq_i      (enq),
        .enq_inst_i (enq_inst),
        .enq_pc_i   (pc),
        .flush_i    (flush),
        .dequeue_i  (dequeue_i),
        .full_o     (full),
        .valid_o    (inst_valid_o),
        .inst_o     (inst_o),
        .pc_o       (inst_pc_o)
    );

endmodule : fetch_top

// File: fetch_assertions.sv
`timescale 1ns/10ps

module fetch_assertions #(
    parameter fetch_pkg::pc_t RESET_PC = fetch_pkg::DEFAULT_RESET_PC
) (
    input logic               clk,
    input logic               rst,
    input mem_bus_pkg::addr_t bmem_addr_i,
    input logic               bmem_read_i,
    input logic               bmem_ready_i,
    input logic               bmem_rvalid_i,
    input logic               redirect_i,
    input fetch_pkg::pc_t     redirect_pc_i,
    input logic               dequeue_i,
    input logic               inst_valid_i,
    input fetch_pkg::word_t   inst_i,
    input fetch_pkg::pc_t     inst_pc_i,
    input fetch_pkg::pc_t     pc_i
);

    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam addr_t FIRST_LINE = RESET_PC & ~addr_t'((1 << LINE_OFFSET_BITS) - 1);
    localparam word_t MEM_KEY    = 32'h5a5a0000;   // memory word = address xor key

    logic       failed;       // sticky, polled by the testbench
    logic [2:0] beats_left;   // beats still owed by the memory
    logic       req_seen;
    pc_t        exp_pc;       // pc the consumer should pop next
    logic       pop;

    initial failed = 1'b0;

    assign pop = inst_valid_i && dequeue_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_pc     <= RESET_PC;
            beats_left <= '0;
            req_seen   <= 1'b0;
        end else begin
            if (redirect_i) begin
                exp_pc <= redirect_pc_i; // older entries are gone
            end else if (pop) begin
                exp_pc <= exp_pc + 32'd4;
            end
            if (bmem_read_i) begin
                beats_left <= 3'(BEATS_PER_LINE);
                req_seen   <= 1'b1;
            end else if (bmem_rvalid_i && beats_left != '0) begin
                beats_left <= beats_left - 3'd1;
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        $past(rst) |-> !inst_valid_i && !bmem_read_i && pc_i == RESET_PC)
        else begin
            failed = 1'b1;
            $error("Fail reset_state: expected valid 0 read 0 pc %h, actual valid %b read %b pc %h",
                   RESET_PC, $sampled(inst_valid_i), $sampled(bmem_read_i), $sampled(pc_i));
        end
    first_req: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i && !req_seen |-> bmem_addr_i == FIRST_LINE)
        else begin
            failed = 1'b1;
            $error("Fail first_req: expected %h, actual %h", FIRST_LINE, $sampled(bmem_addr_i));
        end
    req_ready: assert property (@(posedge clk) disable iff (rst) bmem_read_i |-> bmem_ready_i)
        else begin
            failed = 1'b1;
            $error("line request issued while the memory was not ready");
        end
    req_aligned: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_addr_i[LINE_OFFSET_BITS-1:0] == '0)
        else begin
            failed = 1'b1;
            $error("Fail req_aligned: expected offset 0, actual address %h", $sampled(bmem_addr_i));
        end
    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> beats_left == '0)
        else begin
            failed = 1'b1;
            $error("new line request before the previous burst returned all beats");
        end
    pop_pc: assert property (@(posedge clk) disable iff (rst) pop |-> inst_pc_i == exp_pc)
        else begin
            failed = 1'b1;
            $error("Fail pop_pc: expected %h, actual %h", $sampled(exp_pc), $sampled(inst_pc_i));
        end
    pop_inst: assert property (@(posedge clk) disable iff (rst)
        pop |-> inst_i == (exp_pc ^ MEM_KEY))
        else begin
            failed = 1'b1;
            $error("Fail pop_inst: expected %h, actual %h",
                   $sampled(exp_pc) ^ MEM_KEY, $sampled(inst_i));
        end

endmodule : fetch_assertions

// File: tb_fetch.sv
`timescale 1ns/10ps

module tb_fetch;

    import mem_bus_pkg::*;
    import fetch_pkg::*;

    localparam pc_t   RESET_PC   = DEFAULT_RESET_PC;
    localparam word_t MEM_KEY    = 32'h5a5a0000;
    localparam int    WAIT_LIMIT = 2000;   // cycles per wait loop

    logic  clk;
    logic  rst;
    addr_t bmem_addr_o;
    logic  bmem_read_o;
    logic  bmem_ready_i;
    addr_t bmem_raddr_i;
    beat_t bmem_rdata_i;
    logic  bmem_rvalid_i;
    logic  redirect_i;
    pc_t   redirect_pc_i;
    logic  dequeue_i;
    logic  inst_valid_o;
    word_t inst_o;
    pc_t   inst_pc_o;

    int    seed = 32'hdfd2_2f06;

    // small queue so back-pressure shows up early
    fetch_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(8)) uut (.*);

    bind fetch_top fetch_assertions #(.RESET_PC(RESET_PC)) checks (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_i   (bmem_addr_o),
        .bmem_read_i   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .dequeue_i     (dequeue_i),
        .inst_valid_i  (inst_valid_o),
        .inst_i        (inst_o),
        .inst_pc_i     (inst_pc_o),
        .pc_i          (pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic word_t mem_word(input addr_t a);
        return a ^ MEM_KEY;
    endfunction

    task automatic abort_run(input string reason);
        $display("Errors found");
        $fatal(1, "%s", reason);
    endtask

    // one line as four beats, random gaps before each
    task automatic serve_line(input addr_t base);
        addr_t a;
        for (int b = 0; b < BEATS_PER_LINE; b++) begin
            a = base + addr_t'(8 * b);
            repeat ($random(seed) & 3) begin
                @(posedge clk);
                #1 bmem_rvalid_i = 1'b0;
            end
            @(posedge clk);
            #1;
            bmem_rvalid_i = 1'b1;
            bmem_raddr_i  = base;
            bmem_rdata_i  = {mem_word(a + addr_t'(4)), mem_word(a)};  // low word first
        end
        @(posedge clk);
        #1 bmem_rvalid_i = 1'b0;
    endtask

    task automatic pop_entries(input int n);
        int popped = 0;
        int cycles = 0;
        while (popped < n) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("timeout while popping instructions from the queue");
            end
            @(posedge clk);
            #1 dequeue_i = ($random(seed) & 1) != 0;
            @(negedge clk);
            if (dequeue_i && inst_valid_o) begin
                popped++; // pops at the coming edge
            end
            cycles++;
        end
        @(posedge clk);
        #1 dequeue_i = 1'b0;
    endtask

    task automatic fill_queue();
        int cycles = 0;
        while (!uut.full) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("timeout while waiting for the queue to fill");
            end
            @(negedge clk);
            cycles++;
        end
        repeat (6) @(posedge clk);   // sit under back-pressure a while
    endtask

    task automatic send_redirect(input pc_t target);
        @(posedge clk);
        #1;
        redirect_i    = 1'b1;
        redirect_pc_i = target;
        @(posedge clk);
        #1 redirect_i = 1'b0;
    endtask

    // memory, one burst at a time
    initial begin
        forever begin
            @(negedge clk);
            if (bmem_read_o === 1'b1) begin
                serve_line(bmem_addr_o);
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1 bmem_ready_i = ($random(seed) & 3) != 0;  // busy about one cycle in four
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (uut.checks.failed) begin
                abort_run("a bound assertion failed");
            end
        end
    end

    initial begin
        rst           = 1'b1;
        bmem_ready_i  = 1'b0;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        dequeue_i     = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        pop_entries(40);                 // five lines from the reset vector
        fill_queue();
        pop_entries(20);
        send_redirect(32'h0040_2a18);    // mid line target
        pop_entries(12);
        fill_queue();
        send_redirect(32'h1ecf_00fc);    // last word of a line, queue full
        pop_entries(20);

        repeat (4) @(negedge clk);
        if (uut.checks.failed) begin
            abort_run("a bound assertion failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule : tb_fetch

// File: all.f
mem_bus_pkg.sv
fetch_pkg.sv
burst_assembler.sv
line_buffer.sv
pc_gen.sv
inst_queue.sv
fetch_top.sv
fetch_assertions.sv
tb_fetch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_fetch -Mdir obj_dir -f all.f

./obj_dir/Vtb_fetch +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
grep -q "No errors" sim.log
